// ==== hw/bank_stall_regs.sv ====
// bank stall period registers
`timescale 1ns/1ps
`default_nettype none

module bank_stall_regs #(
  parameter int unsigned NB_CHAN = tcdm_pkg::NB_CHAN_DEF
) (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  input  logic                                           cfg_we_i,
  input  logic [split_cfg_pkg::CFG_ADDR_W-1:0]           cfg_addr_i,
  input  logic [split_cfg_pkg::STALL_W-1:0]              cfg_wdata_i,
  output logic [split_cfg_pkg::STALL_W-1:0]              cfg_rdata_o,
  output logic [NB_CHAN-1:0][split_cfg_pkg::STALL_W-1:0] stall_period_o
);

  logic [NB_CHAN-1:0]                             sel;     // address hits bank i
  logic [NB_CHAN-1:0][split_cfg_pkg::STALL_W-1:0] stall_q;

  for (genvar i = 0; i < NB_CHAN; i++) begin : g_dec
    assign sel[i] = (cfg_addr_i == split_cfg_pkg::stall_addr(i));
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stall_q <= '0;  // all banks grant freely
    end else if (cfg_we_i) begin
      for (int i = 0; i < NB_CHAN; i++) begin
        if (sel[i]) stall_q[i] <= cfg_wdata_i; // unmapped writes fall through
      end
    end
  end

  // read back, unmapped addresses give zero
  always_comb begin
    cfg_rdata_o = '0;
    for (int i = 0; i < NB_CHAN; i++) begin
      if (sel[i]) cfg_rdata_o = stall_q[i];
    end
  end

  assign stall_period_o = stall_q;

endmodule

`default_nettype wire

// ==== hw/chan_fifo.sv ====
// channel fifo
// circular buffer with valid/ready on both sides
`timescale 1ns/1ps
`default_nettype none

module chan_fifo #(
  parameter int unsigned DEPTH     = 2,
  parameter type         payload_t = logic [31:0]
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     clear_i,
  input  logic     push_valid_i,
  input  payload_t push_data_i,
  output logic     push_ready_o,
  output logic     pop_valid_o,
  output payload_t pop_data_o,
  input  logic     pop_ready_i
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];  // storage, no reset
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             alive_q;        // low until the first clock after reset
  logic             full;
  logic             empty;
  logic             push_fire;
  logic             pop_fire;

  // wrap at DEPTH-1, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  if (DEPTH < 1) begin : g_depth_err
    $error("chan_fifo needs DEPTH of at least 1");
  end

  assign full         = (count_q == CNT_W'(DEPTH));
  assign empty        = (count_q == '0);
  assign pop_valid_o  = !empty;
  assign pop_data_o   = mem_q[rd_ptr_q];
  assign push_ready_o = alive_q && (!full || pop_ready_i); // full fifo takes a push on pop
  assign pop_fire     = pop_valid_o && pop_ready_i;
  assign push_fire    = push_valid_i && push_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      alive_q  <= 1'b0;
    end else begin
      alive_q <= 1'b1;
      if (clear_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        count_q  <= '0;
      end else begin
        if (push_fire) wr_ptr_q <= ptr_next(wr_ptr_q);
        if (pop_fire)  rd_ptr_q <= ptr_next(rd_ptr_q);
        case ({push_fire, pop_fire})
          2'b10:   count_q <= count_q + 1'b1;
          2'b01:   count_q <= count_q - 1'b1;
          default: count_q <= count_q;       // both or neither
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_fire) mem_q[wr_ptr_q] <= push_data_i;
  end

  // a push past full would have moved the write pointer off the read pointer
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    full |-> (wr_ptr_q == rd_ptr_q));
  // a pop from empty would have moved the read pointer off the write pointer
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    empty |-> (wr_ptr_q == rd_ptr_q));

endmodule

`default_nettype wire

// ==== hw/split_cfg_pkg.sv ====
// stall register map
`default_nettype none

package split_cfg_pkg;

  localparam int unsigned STALL_W    = 4;  // one stall period field
  localparam int unsigned CFG_ADDR_W = 4;

  // bank 0 period, bank i follows at +i
  localparam logic [CFG_ADDR_W-1:0] STALL_BASE = 4'h4;

  // register address of a bank's stall period
  function automatic logic [CFG_ADDR_W-1:0] stall_addr(input int unsigned bank);
    logic [CFG_ADDR_W-1:0] ofs;
    ofs = CFG_ADDR_W'(bank);
    return STALL_BASE + ofs;
  endfunction

endpackage

`default_nettype wire

// ==== hw/split_mem_top.sv ====
// split memory top
// wide port split over word-interleaved banks
`timescale 1ns/1ps
`default_nettype none

module split_mem_top #(
  parameter int unsigned NB_CHAN     = tcdm_pkg::NB_CHAN_DEF,
  parameter int unsigned DW          = tcdm_pkg::WIDE_DW,
  parameter int unsigned FIFO_DEPTH  = 2,
  parameter int unsigned DEPTH_WORDS = 256
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 clear_i,
  // wide accelerator port
  input  logic                                 req_i,
  input  logic [tcdm_pkg::ADDR_W-1:0]          addr_i,
  input  logic                                 wen_i,
  input  logic [DW/8-1:0]                      be_i,
  input  logic [DW-1:0]                        wdata_i,
  input  logic [tcdm_pkg::UW-1:0]              user_i,
  input  logic                                 r_ready_i,
  output logic                                 gnt_o,
  output logic                                 r_valid_o,
  output logic [DW-1:0]                        r_data_o,
  output logic [tcdm_pkg::UW-1:0]              r_user_o,
  // config port
  input  logic                                 cfg_we_i,
  input  logic [split_cfg_pkg::CFG_ADDR_W-1:0] cfg_addr_i,
  input  logic [split_cfg_pkg::STALL_W-1:0]    cfg_wdata_i,
  output logic [split_cfg_pkg::STALL_W-1:0]    cfg_rdata_o
);

  logic [NB_CHAN-1:0]                             bank_req_valid;
  logic [NB_CHAN-1:0]                             bank_req_ready;
  logic [NB_CHAN-1:0]                             bank_rsp_valid;
  logic [NB_CHAN-1:0]                             bank_rsp_ready;
  tcdm_pkg::narrow_req_t [NB_CHAN-1:0]            bank_req;
  tcdm_pkg::narrow_rsp_t [NB_CHAN-1:0]            bank_rsp;
  logic [NB_CHAN-1:0][split_cfg_pkg::STALL_W-1:0] stall_period;

  wide_port_split #(
    .NB_CHAN    ( NB_CHAN    ),
    .DW         ( DW         ),
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) wide_port_split_inst (
    .clk_i, .rst_ni, .clear_i,
    .req_i, .addr_i, .wen_i, .be_i, .wdata_i, .user_i, .r_ready_i,
    .gnt_o, .r_valid_o, .r_data_o, .r_user_o,
    .bank_req_valid_o ( bank_req_valid ),
    .bank_req_o       ( bank_req       ),
    .bank_req_ready_i ( bank_req_ready ),
    .bank_rsp_valid_i ( bank_rsp_valid ),
    .bank_rsp_i       ( bank_rsp       ),
    .bank_rsp_ready_o ( bank_rsp_ready )
  );

  // stall periods survive clear_i
  bank_stall_regs #(
    .NB_CHAN ( NB_CHAN )
  ) bank_stall_regs_inst (
    .clk_i, .rst_ni, .cfg_we_i, .cfg_addr_i, .cfg_wdata_i, .cfg_rdata_o,
    .stall_period_o ( stall_period )
  );

  for (genvar i = 0; i < NB_CHAN; i++) begin : g_bank
    tcdm_bank #(
      .DEPTH_WORDS ( DEPTH_WORDS )
    ) tcdm_bank_inst (
      .clk_i, .rst_ni, .clear_i,
      .stall_period_i ( stall_period[i]   ),
      .req_valid_i    ( bank_req_valid[i] ),
      .req_i          ( bank_req[i]       ),
      .req_ready_o    ( bank_req_ready[i] ),
      .rsp_valid_o    ( bank_rsp_valid[i] ),
      .rsp_o          ( bank_rsp[i]       ),
      .rsp_ready_i    ( bank_rsp_ready[i] )
    );
  end

endmodule

`default_nettype wire

// ==== hw/tcdm_bank.sv ====
// narrow memory bank
// one cycle read latency, grant throttled by the stall period
`timescale 1ns/1ps
`default_nettype none

module tcdm_bank #(
  parameter int unsigned DEPTH_WORDS = 256
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              clear_i,
  input  logic [split_cfg_pkg::STALL_W-1:0] stall_period_i,
  input  logic                              req_valid_i,
  input  tcdm_pkg::narrow_req_t             req_i,
  output logic                              req_ready_o,
  output logic                              rsp_valid_o,
  output tcdm_pkg::narrow_rsp_t             rsp_o,
  input  logic                              rsp_ready_i
);

  localparam int unsigned IDX_W = (DEPTH_WORDS > 1) ? $clog2(DEPTH_WORDS) : 1;
  localparam int unsigned OFS_W = $clog2(tcdm_pkg::WIDE_DW / 8); // wide word offset bits

  logic [tcdm_pkg::NARROW_DW-1:0]    mem_q [DEPTH_WORDS];
  logic [IDX_W-1:0]                  idx;
  logic [split_cfg_pkg::STALL_W-1:0] stall_cnt_q;  // cycles until next grant
  logic                              rsp_valid_q;
  tcdm_pkg::narrow_rsp_t             rsp_q;
  logic                              grant;
  logic                              rsp_fire;

  // every channel of one wide word lands on the same row
  assign idx = req_i.addr[OFS_W +: IDX_W];

  // no grant while an unaccepted response sits in the output register
  assign req_ready_o = (stall_cnt_q == '0) && (!rsp_valid_q || rsp_ready_i);
  assign grant       = req_valid_i && req_ready_o;
  assign rsp_fire    = rsp_valid_q && rsp_ready_i;
  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stall_cnt_q <= '0;
      rsp_valid_q <= 1'b0;
    end else if (clear_i) begin
      stall_cnt_q <= '0;
      rsp_valid_q <= 1'b0;
    end else begin
      if (grant)                   stall_cnt_q <= stall_period_i; // reload after each grant
      else if (stall_cnt_q != '0)  stall_cnt_q <= stall_cnt_q - 1'b1;
      if (grant)                   rsp_valid_q <= 1'b1;
      else if (rsp_fire)           rsp_valid_q <= 1'b0;
    end
  end

  // memory and response payload
  always_ff @(posedge clk_i) begin
    if (grant) begin
      rsp_q.data <= mem_q[idx];   // old contents, don't-care on writes
      rsp_q.user <= req_i.user;
      for (int b = 0; b < tcdm_pkg::NARROW_BW; b++) begin
        if (!req_i.wen && req_i.be[b]) mem_q[idx][8*b +: 8] <= req_i.data[8*b +: 8];
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/tcdm_pkg.sv ====
// tcdm bus widths and payloads
`default_nettype none

package tcdm_pkg;

  localparam int unsigned ADDR_W      = 32;             // byte address
  localparam int unsigned WIDE_DW     = 64;             // accelerator side data width
  localparam int unsigned UW          = 4;              // user tag, echoed with the response
  localparam int unsigned NB_CHAN_DEF = 2;

  localparam int unsigned NARROW_DW = WIDE_DW / NB_CHAN_DEF; // one bank word
  localparam int unsigned NARROW_BW = NARROW_DW / 8;

  // one slice of a wide request as seen by a bank
  typedef struct packed {
    logic [ADDR_W-1:0]    addr;
    logic                 wen;   // high = read
    logic [NARROW_BW-1:0] be;
    logic [NARROW_DW-1:0] data;
    logic [UW-1:0]        user;
  } narrow_req_t;

  // bank response, data is don't-care for writes
  typedef struct packed {
    logic [NARROW_DW-1:0] data;
    logic [UW-1:0]        user;
  } narrow_rsp_t;

endpackage

`default_nettype wire

// ==== hw/wide_port_split.sv ====
// wide port split
// one wide request into NB_CHAN narrow requests, responses joined back
`timescale 1ns/1ps
`default_nettype none

module wide_port_split #(
  parameter int unsigned NB_CHAN    = 2,
  parameter int unsigned DW         = 64,
  parameter int unsigned FIFO_DEPTH = 2
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                clear_i,
  // wide side
  input  logic                                req_i,
  input  logic [tcdm_pkg::ADDR_W-1:0]         addr_i,
  input  logic                                wen_i,    // high = read
  input  logic [DW/8-1:0]                     be_i,
  input  logic [DW-1:0]                       wdata_i,
  input  logic [tcdm_pkg::UW-1:0]             user_i,
  input  logic                                r_ready_i,
  output logic                                gnt_o,
  output logic                                r_valid_o,
  output logic [DW-1:0]                       r_data_o,
  output logic [tcdm_pkg::UW-1:0]             r_user_o,
  // channel side
  output logic [NB_CHAN-1:0]                  bank_req_valid_o,
  output tcdm_pkg::narrow_req_t [NB_CHAN-1:0] bank_req_o,
  input  logic [NB_CHAN-1:0]                  bank_req_ready_i,
  input  logic [NB_CHAN-1:0]                  bank_rsp_valid_i,
  input  tcdm_pkg::narrow_rsp_t [NB_CHAN-1:0] bank_rsp_i,
  output logic [NB_CHAN-1:0]                  bank_rsp_ready_o
);

  localparam int unsigned DW_OUT = DW / NB_CHAN;
  localparam int unsigned BW_OUT = DW_OUT / 8;

  typedef enum logic { GNT, NO_GNT } gnt_state_t;
  typedef enum logic { RSP_COLLECT, RSP_VALID } rsp_state_t;

  gnt_state_t gnt_cs, gnt_ns;
  rsp_state_t rsp_cs, rsp_ns;

  tcdm_pkg::narrow_req_t [NB_CHAN-1:0] req_slice;
  tcdm_pkg::narrow_rsp_t [NB_CHAN-1:0] rsp_head;       // response fifo outputs
  logic [NB_CHAN-1:0] req_push_valid;
  logic [NB_CHAN-1:0] req_push_ready;
  logic [NB_CHAN-1:0] req_accept;                       // slice taken this cycle
  logic [NB_CHAN-1:0] mask_q, mask_d;                   // slices taken in earlier cycles
  logic [NB_CHAN-1:0] done_mask;
  logic [NB_CHAN-1:0] rsp_head_valid;
  logic               rsp_pop;

  if (DW % NB_CHAN != 0) begin : g_div_err
    $error("wide_port_split needs NB_CHAN to divide DW");
  end

  for (genvar i = 0; i < NB_CHAN; i++) begin : g_chan
    localparam logic [tcdm_pkg::ADDR_W-1:0] ADDR_OFS = i * BW_OUT;

    assign req_slice[i].addr = addr_i + ADDR_OFS;    // word interleaving
    assign req_slice[i].wen  = wen_i;
    assign req_slice[i].be   = be_i[i*BW_OUT +: BW_OUT];
    assign req_slice[i].data = wdata_i[i*DW_OUT +: DW_OUT];
    assign req_slice[i].user = user_i;

    assign req_push_valid[i] = req_i && !done_mask[i]; // never re-present a taken slice
    assign r_data_o[i*DW_OUT +: DW_OUT] = rsp_head[i].data;

    chan_fifo #(
      .DEPTH     ( FIFO_DEPTH             ),
      .payload_t ( tcdm_pkg::narrow_req_t )
    ) req_fifo_inst (
      .clk_i        ( clk_i               ),
      .rst_ni       ( rst_ni              ),
      .clear_i      ( clear_i             ),
      .push_valid_i ( req_push_valid[i]   ),
      .push_data_i  ( req_slice[i]        ),
      .push_ready_o ( req_push_ready[i]   ),
      .pop_valid_o  ( bank_req_valid_o[i] ),
      .pop_data_o   ( bank_req_o[i]       ),
      .pop_ready_i  ( bank_req_ready_i[i] )
    );

    chan_fifo #(
      .DEPTH     ( FIFO_DEPTH             ),
      .payload_t ( tcdm_pkg::narrow_rsp_t )
    ) rsp_fifo_inst (
      .clk_i        ( clk_i               ),
      .rst_ni       ( rst_ni              ),
      .clear_i      ( clear_i             ),
      .push_valid_i ( bank_rsp_valid_i[i] ),
      .push_data_i  ( bank_rsp_i[i]       ),
      .push_ready_o ( bank_rsp_ready_o[i] ),
      .pop_valid_o  ( rsp_head_valid[i]   ),
      .pop_data_o   ( rsp_head[i]         ),
      .pop_ready_i  ( rsp_pop             )   // all channels pop together
    );

    // tags must line up, channel 0 alone is forwarded
    if (i > 0) begin : g_user_chk
      a_user_match: assert property (@(posedge clk_i) disable iff (!rst_ni)
        r_valid_o |-> (rsp_head[i].user == rsp_head[0].user));
    end
  end

  // grant tracking
  assign done_mask  = (gnt_cs == NO_GNT) ? mask_q : '0;
  assign req_accept = req_push_valid & req_push_ready;
  assign gnt_o      = req_i && (&(req_accept | done_mask)); // last missing slices taken

  always_comb begin
    gnt_ns = gnt_cs;
    mask_d = mask_q;
    if (gnt_cs == GNT) begin
      if (req_i && !gnt_o) begin   // partial accept, remember who took it
        gnt_ns = NO_GNT;
        mask_d = req_accept;
      end
    end else if (gnt_o) begin
      gnt_ns = GNT;
      mask_d = '0;
    end else begin
      mask_d = mask_q | req_accept;
    end
  end

  // response tracking, early channel data waits in its fifo
  always_comb begin
    rsp_ns = rsp_cs;
    case (rsp_cs)
      RSP_COLLECT: if (&rsp_head_valid) rsp_ns = RSP_VALID;
      RSP_VALID:   if (r_ready_i) rsp_ns = RSP_COLLECT;
      default:     rsp_ns = RSP_COLLECT;
    endcase
  end

  assign r_valid_o = (rsp_cs == RSP_VALID);
  assign rsp_pop   = r_valid_o && r_ready_i;
  assign r_user_o  = rsp_head[0].user;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_cs <= GNT;
      rsp_cs <= RSP_COLLECT;
      mask_q <= '0;
    end else if (clear_i) begin
      gnt_cs <= GNT;
      rsp_cs <= RSP_COLLECT;
      mask_q <= '0;
    end else begin
      gnt_cs <= gnt_ns;
      rsp_cs <= rsp_ns;
      mask_q <= mask_d;
    end
  end

endmodule

`default_nettype wire

// ==== list.f ====
hw/tcdm_pkg.sv
hw/split_cfg_pkg.sv
hw/chan_fifo.sv
hw/wide_port_split.sv
hw/bank_stall_regs.sv
hw/tcdm_bank.sv
hw/split_mem_top.sv
tb/tb_split_mem.sv

// ==== tb/tb_split_mem.sv ====
// split memory testbench
`timescale 1ns/1ps
`default_nettype none

module tb_split_mem;

  localparam int unsigned DW      = tcdm_pkg::WIDE_DW;
  localparam int unsigned NB      = tcdm_pkg::NB_CHAN_DEF;
  localparam int unsigned MAX_TST = 64;
  localparam int unsigned RST_CYC = 16;
  localparam int          OP_CFG_WR = 0;
  localparam int          OP_CFG_RD = 1;
  localparam int          OP_WR     = 2;
  localparam int          OP_RD     = 3;
  localparam int          OP_CLR    = 4;

  logic                                 clk_i;
  logic                                 rst_ni;
  logic                                 clear_i;
  logic                                 req_i;
  logic [tcdm_pkg::ADDR_W-1:0]          addr_i;
  logic                                 wen_i;
  logic [DW/8-1:0]                      be_i;
  logic [DW-1:0]                        wdata_i;
  logic [tcdm_pkg::UW-1:0]              user_i;
  logic                                 r_ready_i;
  logic                                 gnt_o;
  logic                                 r_valid_o;
  logic [DW-1:0]                        r_data_o;
  logic [tcdm_pkg::UW-1:0]              r_user_o;
  logic                                 cfg_we_i;
  logic [split_cfg_pkg::CFG_ADDR_W-1:0] cfg_addr_i;
  logic [split_cfg_pkg::STALL_W-1:0]    cfg_wdata_i;
  logic [split_cfg_pkg::STALL_W-1:0]    cfg_rdata_o;

  // stimulus table, one entry per test
  string                       tbl_name [MAX_TST];
  int                          tbl_op   [MAX_TST];
  logic [tcdm_pkg::ADDR_W-1:0] tbl_addr [MAX_TST];
  logic [DW/8-1:0]             tbl_be   [MAX_TST];
  logic [DW-1:0]               tbl_data [MAX_TST];
  logic [tcdm_pkg::UW-1:0]     tbl_user [MAX_TST];
  int                          tbl_hold [MAX_TST];  // r_ready low cycles before the response
  logic [DW-1:0]               tbl_exp  [MAX_TST];
  int                          n_tst;

  logic [DW-1:0] ref_mem [256];   // reference memory, one wide word per row
  logic [31:0]   rnd_state;
  int            order [MAX_TST]; // table index of each granted request
  int            n_issued;
  int            n_done;
  int            slice_gnts [NB]; // narrow grants seen at each bank
  int            rsp_hs;          // r_valid/r_ready handshakes
  int            err_count;
  int            tests_done;
  int            cycles;
  int            cycle_limit;

  split_mem_top split_mem_top_inst (.*);

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [DW-1:0] rand_word();
    logic [31:0] hi;
    rnd_state = xorshift(rnd_state);
    hi        = rnd_state;
    rnd_state = xorshift(rnd_state);
    return {hi, rnd_state};
  endfunction

  task automatic add_entry(input string name, input int op, input logic [31:0] addr,
                           input logic [7:0] be, input logic [DW-1:0] data,
                           input logic [3:0] user, input int hold, input logic [DW-1:0] exp);
    tbl_name[n_tst] = name;
    tbl_op[n_tst]   = op;
    tbl_addr[n_tst] = addr;
    tbl_be[n_tst]   = be;
    tbl_data[n_tst] = data;
    tbl_user[n_tst] = user;
    tbl_hold[n_tst] = hold;
    tbl_exp[n_tst]  = exp;
    n_tst++;
  endtask

  // wide write, merged into the reference byte by byte
  task automatic add_wr(input string name, input logic [31:0] addr, input logic [7:0] be,
                        input logic [DW-1:0] data, input logic [3:0] user, input int hold);
    for (int b = 0; b < DW / 8; b++) begin
      if (be[b]) ref_mem[addr[3 +: 8]][8*b +: 8] = data[8*b +: 8];
    end
    add_entry(name, OP_WR, addr, be, data, user, hold, '0);
  endtask

  task automatic add_rd(input string name, input logic [31:0] addr, input logic [3:0] user,
                        input int hold);
    add_entry(name, OP_RD, addr, '0, '0, user, hold, ref_mem[addr[3 +: 8]]);
  endtask

  task automatic build_table();
    logic [31:0] sb;
    sb = 32'(split_cfg_pkg::STALL_BASE);
    add_entry("cfg_wr_bank0", OP_CFG_WR, sb, '0, 64'd5, '0, 0, '0);
    add_entry("cfg_wr_bank1", OP_CFG_WR, sb + 1, '0, 64'd9, '0, 0, '0);
    add_entry("cfg_rd_bank0", OP_CFG_RD, sb, '0, '0, '0, 0, 64'd5);
    add_entry("cfg_rd_bank1", OP_CFG_RD, sb + 1, '0, '0, '0, 0, 64'd9);
    add_entry("cfg_rd_unmapped_lo", OP_CFG_RD, 32'h0, '0, '0, '0, 0, '0);
    add_entry("cfg_rd_unmapped_hi", OP_CFG_RD, 32'hf, '0, '0, '0, 0, '0);
    add_entry("cfg_zero_bank0", OP_CFG_WR, sb, '0, '0, '0, 0, '0);
    add_entry("cfg_zero_bank1", OP_CFG_WR, sb + 1, '0, '0, '0, 0, '0);
    for (int k = 0; k < 4; k++) begin  // full width round trip
      add_wr($sformatf("rt_wr%0d", k), 32'(8 * k), 8'hff, rand_word(), 4'(k), 0);
    end
    for (int k = 0; k < 4; k++) begin
      add_rd($sformatf("rt_rd%0d", k), 32'(8 * k), 4'(k + 4), 0);
    end
    add_wr("be_mid", 32'h08, 8'h3c, rand_word(), 4'h1, 0);  // bytes 2..5 cross the slices
    add_wr("be_ends", 32'h10, 8'h81, rand_word(), 4'h2, 0);
    add_wr("be_pair", 32'h18, 8'h18, rand_word(), 4'h3, 0);
    add_rd("be_rd_mid", 32'h08, 4'h9, 0);
    add_rd("be_rd_ends", 32'h10, 4'ha, 0);
    add_rd("be_rd_pair", 32'h18, 4'hb, 0);
    add_entry("skew_bank0", OP_CFG_WR, sb, '0, 64'd0, '0, 0, '0);
    add_entry("skew_bank1", OP_CFG_WR, sb + 1, '0, 64'd3, '0, 0, '0);
    for (int k = 0; k < 6; k++) begin  // back to back, bank 1 lags
      add_wr($sformatf("skew_wr%0d", k), 32'(32 + 8 * k), 8'hff, rand_word(), 4'(k), 0);
      add_rd($sformatf("skew_rd%0d", k), 32'(32 + 8 * k), 4'(k + 8), 0);
    end
    for (int k = 0; k < 6; k++) begin  // r_ready held off, fifos fill up
      add_rd($sformatf("bp_rd%0d", k), 32'(32 + 8 * k), 4'(15 - k), 10);
    end
    add_entry("clear_pulse", OP_CLR, '0, '0, '0, '0, 0, '0);
    add_entry("clr_cfg_bank1", OP_CFG_RD, sb + 1, '0, '0, '0, 0, 64'd3);
    add_entry("clr_cfg_bank0", OP_CFG_RD, sb, '0, '0, '0, 0, 64'd0);
    add_rd("clr_rd_0", 32'h00, 4'h5, 0);
    add_rd("clr_rd_1", 32'h08, 4'h6, 0);
    add_rd("clr_rd_2", 32'h28, 4'h7, 0);
  endtask

  task automatic check_data(input string name, input logic [tcdm_pkg::WIDE_DW-1:0] exp,
                            input logic [tcdm_pkg::WIDE_DW-1:0] act);
    if (act !== exp) begin
      $display("Error %s: expected %h, actual %h", name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_user(input string name, input logic [tcdm_pkg::UW-1:0] exp,
                            input logic [tcdm_pkg::UW-1:0] act);
    if (act !== exp) begin
      $display("Error %s: expected user %h, actual user %h", name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_cfg(input string name, input logic [split_cfg_pkg::STALL_W-1:0] exp,
                           input logic [split_cfg_pkg::STALL_W-1:0] act);
    if (act !== exp) begin
      $display("Error %s: expected %0d, actual %0d", name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("Error %s: expected %0d, actual %0d", name, exp, act);
      err_count++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("%-20s %s", name, (err_count == errs_before) ? "ok" : "mismatch");
    tests_done++;
  endtask

  // present one wide request until the handshake
  task automatic issue_wide(input int idx);
    req_i   = 1'b1;
    addr_i  = tbl_addr[idx];
    wen_i   = (tbl_op[idx] == OP_RD);
    be_i    = tbl_be[idx];
    wdata_i = tbl_data[idx];
    user_i  = tbl_user[idx];
    @(negedge clk_i);
    while (!gnt_o) @(negedge clk_i);
    order[n_issued] = idx;  // accepted on the coming edge
    n_issued++;
    @(posedge clk_i);
    #2;
    req_i = 1'b0;
  endtask

  // wait until every accepted request has been answered and nothing else shows up
  task automatic drain();
    while (n_done != n_issued) begin
      @(posedge clk_i);
      #2;
    end
    repeat (4) @(posedge clk_i);   // a stray response would be taken here
    #2;
    for (int c = 0; c < NB; c++) begin
      check_count($sformatf("bank %0d grants", c), n_issued, slice_gnts[c]);
    end
    check_count("response handshakes", n_issued, rsp_hs);
  endtask

  always @(negedge clk_i) begin
    if (rst_ni) begin
      for (int c = 0; c < NB; c++) begin
        if (split_mem_top_inst.bank_req_valid[c] && split_mem_top_inst.bank_req_ready[c])
          slice_gnts[c]++;
      end
    end
    if (r_valid_o && r_ready_i) rsp_hs++;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("The run was stopped because the tests did not finish in %0d cycles.",
               cycle_limit);
      $display("tests failed");
      $finish;
    end
  end

  // response side, answers come back in request order
  initial begin : collect
    int idx;
    int errs;
    forever begin
      @(posedge clk_i);
      if (n_done != n_issued) begin
        idx = order[n_done];
        if (tbl_hold[idx] > 0) begin
          #2;
          r_ready_i = 1'b0;                          // back-pressure
          repeat (tbl_hold[idx]) @(posedge clk_i);
          #2;
          r_ready_i = 1'b1;
        end
        @(negedge clk_i);
        while (!r_valid_o) @(negedge clk_i);
        errs = err_count;
        if (tbl_op[idx] == OP_RD) check_data(tbl_name[idx], tbl_exp[idx], r_data_o);
        check_user(tbl_name[idx], tbl_user[idx], r_user_o);
        report_test(tbl_name[idx], errs);
        n_done++;
      end
    end
  end

  initial begin : main
    int errs;
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    clear_i     = 1'b0;
    req_i       = 1'b0;
    addr_i      = '0;
    wen_i       = 1'b1;
    be_i        = '0;
    wdata_i     = '0;
    user_i      = '0;
    r_ready_i   = 1'b1;   // ready while idle
    cfg_we_i    = 1'b0;
    cfg_addr_i  = '0;
    cfg_wdata_i = '0;
    rnd_state   = 32'd67036;
    n_tst       = 0;
    n_issued    = 0;
    n_done      = 0;
    rsp_hs      = 0;
    err_count   = 0;
    tests_done  = 0;
    cycles      = 0;
    foreach (slice_gnts[c]) slice_gnts[c] = 0;
    build_table();
    cycle_limit = 200 * n_tst + RST_CYC;
    repeat (RST_CYC) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    for (int t = 0; t < n_tst; t++) begin
      case (tbl_op[t])
        OP_WR, OP_RD: issue_wide(t);
        OP_CFG_WR: begin
          drain();
          cfg_we_i    = 1'b1;
          cfg_addr_i  = tbl_addr[t][split_cfg_pkg::CFG_ADDR_W-1:0];
          cfg_wdata_i = tbl_data[t][split_cfg_pkg::STALL_W-1:0];
          @(posedge clk_i);
          #2;
          cfg_we_i = 1'b0;
          report_test(tbl_name[t], err_count);
        end
        OP_CFG_RD: begin
          drain();
          errs       = err_count;
          cfg_addr_i = tbl_addr[t][split_cfg_pkg::CFG_ADDR_W-1:0];
          @(negedge clk_i);                          // read-back is combinational
          check_cfg(tbl_name[t], tbl_exp[t][split_cfg_pkg::STALL_W-1:0], cfg_rdata_o);
          report_test(tbl_name[t], errs);
          @(posedge clk_i);
          #2;
        end
        default: begin                               // clear pulse
          drain();
          clear_i = 1'b1;
          @(posedge clk_i);
          #2;
          clear_i = 1'b0;
          report_test(tbl_name[t], err_count);
        end
      endcase
    end
    drain();
    $display("%0d tests run, %0d errors", tests_done, err_count);
    if (err_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
